// File: files.f
design/oversampler_pkg.sv
design/sample_front.sv
design/phase_picker.sv
design/link_monitor.sv
design/phase_fsm.sv
design/oversampler_top.sv
verification/oversampler_checker.sv
verification/tb_oversampler.sv

// File: Bender.yml
package:
  name: oversampler

sources:
  - files:
      - design/oversampler_pkg.sv
      - design/sample_front.sv
      - design/phase_picker.sv
      - design/link_monitor.sv
      - design/phase_fsm.sv
      - design/oversampler_top.sv
  - target: test
    files:
      - verification/oversampler_checker.sv
      - verification/tb_oversampler.sv

// File: verification/tb_oversampler.sv
// oversampler testbench
// drives oversampled bit streams into the phase-picking core and
// steers the checker through clean, inverted, pulsed and edge-heavy traffic

`default_nettype none

module tb_oversampler
  import oversampler_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CNT_W          = 8;
  localparam int N_RANDOM       = 1000;  // clean random traffic
  localparam int N_INVERT       = 700;   // same with output polarity flipped
  localparam int N_PULSES       = 40;    // isolated edge hits at phase 0
  localparam int PULSE_GAP      = 12;
  localparam int MOVE_LIMIT     = 40;
  localparam int SETTLE         = 8;
  localparam int N_AFTER_MOVE   = 200;
  localparam int TIMEOUT_CYCLES = 4000;  // run is about 2500 cycles

  logic             fastclock = 1'b0;
  logic             rst_n;
  sample_vec_t      rx_samples;
  logic             invert;
  logic [CNT_W-1:0] stable_to_reset;
  logic [CNT_W-1:0] err_to_shift;
  phase_sel_t       phase_sel_out;
  logic             phase_err;
  logic             d0;
  logic             d1;
  logic             check_en;
  phase_sel_t       exp_phase;
  int               value_errs;
  int               move_misses;
  int               cycles;
  logic [15:0]      lfsr;
  logic             last_bit;   // newest stream bit already on the wire
  logic             moved;

  oversampler_top #(
    .CNT_W (CNT_W)
  ) i_dut (
    .fastclock       (fastclock),
    .rst_n           (rst_n),
    .rx_samples      (rx_samples),
    .invert          (invert),
    .stable_to_reset (stable_to_reset),
    .err_to_shift    (err_to_shift),
    .phase_sel_out   (phase_sel_out),
    .phase_err       (phase_err),
    .d0              (d0),
    .d1              (d1)
  );

  oversampler_checker i_checker (
    .fastclock     (fastclock),
    .rst_n         (rst_n),
    .rx_samples    (rx_samples),
    .invert        (invert),
    .phase_sel_out (phase_sel_out),
    .phase_err     (phase_err),
    .d0            (d0),
    .d1            (d1),
    .check_en      (check_en),
    .exp_phase     (exp_phase),
    .value_errs    (value_errs)
  );

  // ------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  // phases 0..e still see the older bit and e+1..3 the window's new bit
  function automatic sample_vec_t build_vector(input int e, input logic pb, input logic fb,
                                               input logic rb);
    sample_vec_t v;
    for (int p = 0; p < 4; p++) begin
      v[p]     = (p <= e) ? pb : fb;  // falling window
      v[p + 4] = (p <= e) ? fb : rb;  // rising window
    end
    for (int i = 0; i < 8; i += 2) begin
      v[i] = ~v[i];  // complementary receiver leg
    end
    return v;
  endfunction

  task automatic send_vector(input int e, input logic fb, input logic rb, input logic inv);
    @(posedge fastclock);
    rx_samples <= build_vector(e, last_bit, fb, rb);
    invert     <= inv;
    last_bit    = rb;
  endtask

  task automatic send_random(input int e, input logic inv);
    logic fb;
    logic rb;
    take_bit(fb);
    take_bit(rb);
    send_vector(e, fb, rb, inv);
  endtask

  // both windows flip with the edge right after phase 0
  task automatic send_toggle();
    send_vector(0, ~last_bit, last_bit, 1'b0);
  endtask

  // ------------------------------------------------
  // clock, timeout and sequences
  // ------------------------------------------------

  initial begin
    forever #2 fastclock = ~fastclock;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge fastclock);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    rst_n           = 1'b0;
    rx_samples      = '0;
    invert          = 1'b0;
    stable_to_reset = 8;
    err_to_shift    = 4;
    check_en        = 1'b1;
    exp_phase       = 2'd0;
    move_misses     = 0;
    lfsr            = 16'd42;
    last_bit        = 1'b0;
    moved           = 1'b0;
    repeat (3) @(posedge fastclock);
    rst_n <= 1'b1;
    repeat (N_RANDOM) send_random(2, 1'b0);  // edge far from phase 0
    repeat (N_INVERT) send_random(2, 1'b1);
    repeat (N_PULSES) begin  // lone errors that the stable run forgets
      send_toggle();
      repeat (PULSE_GAP) send_random(2, 1'b0);
    end
    check_en <= 1'b0;  // phase is expected to move now
    for (int i = 0; i < MOVE_LIMIT && !moved; i++) begin
      send_toggle();
      @(negedge fastclock);
      if (phase_sel_out == 2'd2) moved = 1'b1;  // sm_10 sits clear of the phase 0 edge
    end
    if (!moved) begin
      $display("phase_sel_out did not move to 2 within %0d cycles of alternating data",
               MOVE_LIMIT);
      move_misses++;
    end
    send_toggle();
    exp_phase <= 2'd2;
    repeat (SETTLE) send_toggle();
    check_en <= 1'b1;
    repeat (N_AFTER_MOVE) send_toggle();
    repeat (4) send_toggle();
    @(negedge fastclock);
    $display("summary: %0d value mismatches, %0d missed phase moves", value_errs, move_misses);
    if (value_errs == 0 && move_misses == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/oversampler_checker.sv
// oversampler checker
// rebuilds d0, d1 and phase_err from the sample history and compares
// them with the DUT outputs at the fixed pipeline latency

`default_nettype none

module oversampler_checker
  import oversampler_pkg::*;
(
  input  logic        fastclock,
  input  logic        rst_n,
  input  sample_vec_t rx_samples,
  input  logic        invert,
  input  phase_sel_t  phase_sel_out,
  input  logic        phase_err,
  input  logic        d0,
  input  logic        d1,
  input  logic        check_en,    // low while the phase is allowed to move
  input  phase_sel_t  exp_phase,   // phase code the core should hold
  output int          value_errs
);

  timeunit 1ns;
  timeprecision 1ps;

  sample_vec_t hist [4];     // rx_samples at the last four falling edges with [0] newest
  logic        perr_q;       // expected phase_err due at the next falling edge
  logic [1:0]  data_q [2];   // expected {d0, d1} due two falling edges on
  logic [2:0]  res;
  int          since_rst;    // falling edges seen with reset released

  // expected {d0, d1, phase_err} for one raw vector and the vector before it
  function automatic logic [2:0] expect_bits(input sample_vec_t raw, input sample_vec_t raw_prev,
                                             input logic inv, input phase_sel_t code);
    logic [7:0] t;
    logic [7:0] tp;
    logic [3:0] edg;
    int         j;
    for (int i = 0; i < 8; i++) begin
      t[i]  = (i % 2 == 0) ? ~raw[i] : raw[i];            // even legs come in inverted
      tp[i] = (i % 2 == 0) ? ~raw_prev[i] : raw_prev[i];
    end
    for (int k = 0; k < 3; k++) begin
      edg[k] = (t[k] != t[k + 1]) || (t[k + 4] != t[k + 5]);
    end
    edg[3] = (t[3] != t[4]) || (tp[7] != t[0]);  // wraps into the previous cycle
    case (code)
      2'd0:    j = 0;
      2'd1:    j = 1;
      2'd3:    j = 2;
      default: j = 3;
    endcase
    return {t[j + 4] ^ inv, t[j] ^ inv, edg[j] | edg[(j + 3) % 4]};
  endfunction

  task automatic check_value(input string name, input logic [1:0] expected,
                             input logic [1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
      value_errs++;
    end
  endtask

  initial value_errs = 0;

  // ------------------------------------------------
  // compare on the falling edge while outputs are settled
  // ------------------------------------------------

  always @(negedge fastclock) begin
    if (!rst_n) begin
      since_rst = 0;
    end else if (since_rst < 100) begin
      since_rst++;
    end
    if (since_rst <= 2) begin
      // everything reads zero in reset and one cycle after it
      check_value("d0", 2'd0, {1'b0, d0});
      check_value("d1", 2'd0, {1'b0, d1});
      check_value("phase_err", 2'd0, {1'b0, phase_err});
      check_value("phase_sel_out", 2'd0, phase_sel_out);
    end else if (check_en) begin
      check_value("phase_sel_out", exp_phase, phase_sel_out);
      if (since_rst >= 5) check_value("phase_err", {1'b0, perr_q}, {1'b0, phase_err});
      if (since_rst >= 6) begin  // pipeline holds real data from here on
        check_value("d0", {1'b0, data_q[1][1]}, {1'b0, d0});
        check_value("d1", {1'b0, data_q[1][0]}, {1'b0, d1});
      end
    end
    hist[3] = hist[2];
    hist[2] = hist[1];
    hist[1] = hist[0];
    hist[0] = rx_samples;
    res       = expect_bits(hist[2], hist[3], invert, exp_phase);  // sits in front now
    data_q[1] = data_q[0];
    data_q[0] = res[2:1];
    perr_q    = res[0];
  end

endmodule

`default_nettype wire

// File: design/oversampler_top.sv
// oversampler phase-picking core
// front end, phase picker, link monitor and phase FSM on one clock

`default_nettype none

module oversampler_top
  import oversampler_pkg::*;
#(
  parameter int CNT_W = DEFAULT_CNT_W  // counter and threshold width
) (
  input  logic             fastclock,
  input  logic             rst_n,
  input  sample_vec_t      rx_samples,
  input  logic             invert,
  input  logic [CNT_W-1:0] stable_to_reset,
  input  logic [CNT_W-1:0] err_to_shift,
  output phase_sel_t       phase_sel_out,
  output logic             phase_err,
  output logic             d0,
  output logic             d1
);

  front_out_t front;          // restored samples and edge flags
  logic       vote_to_shift;

  // ------------------------------------------------
  // datapath
  // ------------------------------------------------

  sample_front i_sample_front (
    .fastclock  (fastclock),
    .rst_n      (rst_n),
    .rx_samples (rx_samples),
    .front      (front)
  );

  phase_picker i_phase_picker (
    .fastclock (fastclock),
    .rst_n     (rst_n),
    .front     (front),
    .phase_sel (phase_sel_out),
    .invert    (invert),
    .phase_err (phase_err),
    .d0        (d0),
    .d1        (d1)
  );

  // ------------------------------------------------
  // phase control loop
  // ------------------------------------------------

  link_monitor #(
    .CNT_W (CNT_W)
  ) i_link_monitor (
    .fastclock       (fastclock),
    .rst_n           (rst_n),
    .phase_err       (phase_err),
    .phase_sel       (phase_sel_out),
    .stable_to_reset (stable_to_reset),
    .err_to_shift    (err_to_shift),
    .vote_to_shift   (vote_to_shift)
  );

  phase_fsm i_phase_fsm (
    .fastclock     (fastclock),
    .rst_n         (rst_n),
    .front         (front),
    .vote_to_shift (vote_to_shift),
    .phase_sel     (phase_sel_out)
  );

endmodule

`default_nettype wire

// File: design/phase_fsm.sv
// phase selection FSM
// on each vote steps the sample phase away from the detected edges

`default_nettype none

module phase_fsm
  import oversampler_pkg::*;
(
  input  logic       fastclock,
  input  logic       rst_n,
  input  front_out_t front,
  input  logic       vote_to_shift,
  output phase_sel_t phase_sel
);

  phase_state_e state;
  phase_state_e state_next;
  edge_vec_t    edges;

  assign edges = front.edges;  // samples unused here

  // ------------------------------------------------
  // transition table
  // ------------------------------------------------

  always_comb begin
    state_next = state;  // hold unless an edge crowds us
    case (state)
      sm_00: begin
        if (edges[0])      state_next = sm_10;
        else if (edges[3]) state_next = sm_01;
      end
      sm_01: begin
        if (edges[1])      state_next = sm_00;
        else if (edges[0]) state_next = sm_11;
      end
      sm_11: begin
        if (edges[2])      state_next = sm_01;
        else if (edges[1]) state_next = sm_10;
      end
      sm_10: begin
        if (edges[3])      state_next = sm_11;
        else if (edges[2]) state_next = sm_00;
      end
      default: state_next = sm_00;
    endcase
  end

  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      state <= sm_00;
    end else if (vote_to_shift) begin  // only move when the monitor agrees
      state <= state_next;
    end
  end

  assign phase_sel = phase_sel_t'(state);  // state code is the select code

  // no vote, no move
  a_hold_without_vote : assert property (
    @(posedge fastclock) disable iff (!rst_n)
    !vote_to_shift |=> (state == $past(state))
  );

endmodule

`default_nettype wire

// File: design/link_monitor.sv
// link monitor
// hysteresis on phase errors: a long clean run forgets old errors,
// enough errors without one raises the vote to shift phase

`default_nettype none

module link_monitor
  import oversampler_pkg::*;
#(
  parameter int CNT_W = DEFAULT_CNT_W
) (
  input  logic             fastclock,
  input  logic             rst_n,
  input  logic             phase_err,
  input  phase_sel_t       phase_sel,
  input  logic [CNT_W-1:0] stable_to_reset,
  input  logic [CNT_W-1:0] err_to_shift,
  output logic             vote_to_shift
);

  logic [CNT_W-1:0] stable_count;  // clean cycles since last error
  logic [CNT_W-1:0] err_count;     // errors since link was last stable
  logic             link_stable;
  phase_sel_t       phase_sel_last;
  logic             phase_moved;

  assign phase_moved = (phase_sel_last != phase_sel);

  // ------------------------------------------------
  // stable-run counter
  // ------------------------------------------------

  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      stable_count <= '0;
      link_stable  <= 1'b0;
    end else begin
      if (phase_err) begin
        stable_count <= '0;                   // any error restarts the run
      end else if (stable_count < stable_to_reset) begin
        stable_count <= stable_count + 1'b1;
      end
      link_stable <= (stable_count == stable_to_reset);
    end
  end

  // ------------------------------------------------
  // error counter and vote
  // ------------------------------------------------

  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      err_count      <= '0;
      vote_to_shift  <= 1'b0;
      phase_sel_last <= '0;
    end else begin
      phase_sel_last <= phase_sel;            // lets us see a move one cycle late
      if (link_stable || phase_moved) begin
        err_count <= '0;                      // fresh count after each move
      end else if (phase_err && (err_count < err_to_shift)) begin
        err_count <= err_count + 1'b1;        // saturates at threshold
      end
      vote_to_shift <= (err_count == err_to_shift);
    end
  end

  // saturation holds across the whole run, including after phase moves
  a_err_count_bounded : assert property (
    @(posedge fastclock) disable iff (!rst_n)
    $past(rst_n) |-> (err_count <= err_to_shift)
  );

endmodule

`default_nettype wire

// File: design/phase_picker.sv
// phase picker
// chooses the sample pair for the current phase, applies output
// polarity and raises a phase error when an edge hugs that phase

`default_nettype none

module phase_picker
  import oversampler_pkg::*;
(
  input  logic       fastclock,
  input  logic       rst_n,
  input  front_out_t front,
  input  phase_sel_t phase_sel,
  input  logic       invert,
  output logic       phase_err,
  output logic       d0,
  output logic       d1
);

  logic [3:0] err_term;      // per-phase error, indexed by phase
  logic [1:0] phase_idx;     // sample phase picked by the code
  logic [2:0] rise_idx;      // same phase in the rising window
  logic       rising_next;
  logic       falling_next;
  logic       rising;
  logic       falling;

  // ------------------------------------------------
  // selection
  // ------------------------------------------------

  // phase j is unsafe when an edge sits on either side of it
  always_comb begin
    for (int j = 0; j < 4; j++) begin
      err_term[j] = front.edges[j] || front.edges[(j + 3) % 4];
    end
  end

  always_comb begin
    case (phase_sel)
      2'd0:    phase_idx = 2'd0;
      2'd1:    phase_idx = 2'd1;
      2'd3:    phase_idx = 2'd2;  // gray order, 3 before 2
      default: phase_idx = 2'd3;
    endcase
  end

  assign rise_idx     = {1'b1, phase_idx};                      // j + 4
  assign falling_next = front.samples[phase_idx] ^ invert;
  assign rising_next  = front.samples[rise_idx] ^ invert;

  // ------------------------------------------------
  // output registers
  // ------------------------------------------------

  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      phase_err <= 1'b0;
    end else begin
      phase_err <= err_term[phase_idx];
    end
  end

  always_ff @(posedge fastclock) begin
    rising  <= rising_next;   // recovered bits, no reset
    falling <= falling_next;
  end

  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      d0 <= 1'b0;
      d1 <= 1'b0;
    end else begin
      d0 <= rising;
      d1 <= falling;
    end
  end

  // outputs must be quiet right after reset hits, whatever sits in the pipe
  a_quiet_after_reset : assert property (
    @(posedge fastclock) !rst_n |=> (!d0 && !d1)
  );

endmodule

`default_nettype wire

// File: design/sample_front.sv
// sample front end
// registers the raw oversampled vector, restores the even samples
// and flags data edges between neighbouring phases

`default_nettype none

module sample_front
  import oversampler_pkg::*;
(
  input  logic        fastclock,
  input  logic        rst_n,
  input  sample_vec_t rx_samples,
  output front_out_t  front
);

  sample_vec_t ii;   // raw samples, one cycle after the pins
  sample_vec_t id;   // true-value samples
  edge_vec_t   eq4;  // edge flags built from raw neighbours

  // ------------------------------------------------
  // input register
  // ------------------------------------------------

  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      ii <= '0;
    end else begin
      ii <= rx_samples;
    end
  end

  // ------------------------------------------------
  // un-inversion and edge detection
  // ------------------------------------------------

  assign id = ii ^ EVEN_INVERT_MASK;  // flip the even legs back

  // neighbours sit on opposite legs, so equal raw bits mean the data moved
  always_comb begin
    eq4[0] = (ii[0] == ii[1]) || (ii[4] == ii[5]);
    eq4[1] = (ii[1] == ii[2]) || (ii[5] == ii[6]);
    eq4[2] = (ii[2] == ii[3]) || (ii[6] == ii[7]);
    // wrap from last phase of previous cycle, held as true value in front
    eq4[3] = (ii[3] == ii[4]) || (front.samples[7] == ii[0]);
  end

  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      front <= '0;
    end else begin
      front.samples <= id;
      front.edges   <= eq4;
    end
  end

  // front carries exactly the restored copy of the raw register one cycle on
  a_front_uninvert : assert property (
    @(posedge fastclock) disable iff (!rst_n)
    $past(rst_n) |-> (front.samples == ($past(ii) ^ EVEN_INVERT_MASK))
  );

endmodule

`default_nettype wire

// File: design/oversampler_pkg.sv
// oversampler package
// sample, edge and phase-select types, the phase state encoding
// and the front-end bundle shared by the phase-picking core

`default_nettype none

package oversampler_pkg;

  // ------------------------------------------------
  // widths
  // ------------------------------------------------

  // one cycle of samples, index = half*4 + phase
  // 0..3 falling-bit window, 4..7 rising-bit window
  typedef logic [7:0] sample_vec_t;

  // bit k set when a transition falls between phase k and k+1
  typedef logic [3:0] edge_vec_t;

  typedef logic [1:0] phase_sel_t;  // phase-select code, gray ordered

  // ------------------------------------------------
  // phase state machine
  // ------------------------------------------------

  // state value doubles as the phase-select code
  typedef enum logic [1:0] {
    sm_00 = 2'd0,
    sm_01 = 2'd1,
    sm_10 = 2'd2,
    sm_11 = 2'd3
  } phase_state_e;

  // ------------------------------------------------
  // front end output
  // ------------------------------------------------

  typedef struct packed {
    sample_vec_t samples;  // true-value samples (id)
    edge_vec_t   edges;    // adjacent-phase edge flags (eq4)
  } front_out_t;

  // even samples come from the complementary leg
  localparam sample_vec_t EVEN_INVERT_MASK = 8'h55;

  localparam int DEFAULT_CNT_W = 8;  // counter and threshold width

endpackage

`default_nettype wire
